/* testbench/corePatterns.txt */
# P  word address (hex)  initial word      program and data
# E  word address (hex)  expected word     checked after the final halt
P 00 ffb00093  addi x1, x0, -5
P 01 fe400193  addi x3, x0, -28
P 02 12345137  lui x2, 0x12345
P 03 00202023  sw x2, 0(x0)
P 04 67810113  addi x2, x2, 0x678
P 05 002020a3  sw x2, 1(x0)
P 06 00208233  add x4, x1, x2
P 07 401102b3  sub x5, x2, x1
P 08 00314333  xor x6, x2, x3
P 09 003163b3  or x7, x2, x3
P 0a 00317433  and x8, x2, x3
P 0b 0020a4b3  slt x9, x1, x2
P 0c 0020b533  sltu x10, x1, x2
P 0d 003115b3  sll x11, x2, x3
P 0e 0030d633  srl x12, x1, x3
P 0f fff14693  xori x13, x2, -1
P 10 70016713  ori x14, x2, 0x700
P 11 ff017793  andi x15, x2, -16
P 12 0010a813  slti x16, x1, 1
P 13 fff0b893  sltiu x17, x1, -1
P 14 00811913  slli x18, x2, 8
P 15 0080d993  srli x19, x1, 8
P 16 4046da13  srai x20, x13, 4
P 17 00402123  sw x4, 2(x0)
P 18 005021a3  sw x5, 3(x0)
P 19 00602223  sw x6, 4(x0)
P 1a 007022a3  sw x7, 5(x0)
P 1b 00802323  sw x8, 6(x0)
P 1c 009023a3  sw x9, 7(x0)
P 1d 00a02423  sw x10, 8(x0)
P 1e 00b024a3  sw x11, 9(x0)
P 1f 00c02523  sw x12, 10(x0)
P 20 00d025a3  sw x13, 11(x0)
P 21 00e02623  sw x14, 12(x0)
P 22 00f026a3  sw x15, 13(x0)
P 23 01002723  sw x16, 14(x0)
P 24 011027a3  sw x17, 15(x0)
P 25 01202823  sw x18, 16(x0)
P 26 013028a3  sw x19, 17(x0)
P 27 01402923  sw x20, 18(x0)
P 28 03c00a83  lb x21, 60(x0)
P 29 03c04b03  lbu x22, 60(x0)
P 2a 03c01b83  lh x23, 60(x0)
P 2b 03c05c03  lhu x24, 60(x0)
P 2c 03c02c83  lw x25, 60(x0)
P 2d 015029a3  sw x21, 19(x0)
P 2e 01602a23  sw x22, 20(x0)
P 2f 01702aa3  sw x23, 21(x0)
P 30 01802b23  sw x24, 22(x0)
P 31 01902ba3  sw x25, 23(x0)
P 32 02200ea3  sb x2, 61(x0)
P 33 02201f23  sh x2, 62(x0)
P 34 0000007f  halt
P 35 00102c23  sw x1, 24(x0)
P 36 022082b3  funct7 01 on OP, invalid
P 37 02502ca3  sw x5, 57(x0)
P 38 0000007f  halt
P 39 0badf00d  target of the store behind the invalid word
P 3c cafeb586  load source
P 3d a5a5a5a5  byte store target
P 3e 5a5a5a5a  halfword store target
E 00 12345000  lui
E 01 12345678  addi
E 02 12345673  add
E 03 1234567d  sub
E 04 edcba99c  xor
E 05 fffffffc  or
E 06 12345660  and
E 07 00000001  slt, negative below positive
E 08 00000000  sltu
E 09 23456780  sll by the low 5 bits of rs2
E 0a 0fffffff  srl
E 0b edcba987  xori with -1
E 0c 12345778  ori
E 0d 12345670  andi with -16
E 0e 00000001  slti
E 0f 00000001  sltiu against sign-extended -1
E 10 34567800  slli
E 11 00ffffff  srli
E 12 fedcba98  srai
E 13 ffffff86  lb
E 14 00000086  lbu
E 15 ffffb586  lh
E 16 0000b586  lhu
E 17 cafeb586  lw
E 18 fffffffb  store after restart
E 39 1234567d  x5 kept its sub result
E 3c cafeb586
E 3d a5a5a578  lane 0 only
E 3e 5a5a5678  lanes 0 and 1 only

/* vlog.f */
+incdir+verilog
verilog/rvIsaPkg.sv
verilog/coreCtrlPkg.sv
verilog/busSequencer.sv
verilog/instDecoder.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/loadStoreAlign.sv
verilog/miniRvCore.sv
testbench/miniRvCoreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f vlog.f --top-module miniRvCoreTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
   exit 0
fi
exit 1

/* testbench/miniRvCoreTb.sv */
`include "coreCfg.svh"

module miniRvCoreTb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int memWords   = 64;
   localparam int resumeAddr = 24; // first store after the halt opcode
   localparam int skipAddr   = 57; // store behind the invalid word

   logic                 clk = 1'b0;
   logic                 rstn;
   logic                 start;
   logic                 rVld;
   logic [`XLEN-1:0]     rData;
   logic                 rRdy;
   logic [`XLEN-1:0]     rAddr;
   logic                 rWEn;
   logic [`XLEN-1:0]     rWData;
   logic [`STROBE_W-1:0] rWStrobe;
   logic                 halt;

   logic [`XLEN-1:0] mem [memWords];
   logic [`XLEN-1:0] initMem [memWords];
   int               expAddr[$];
   logic [`XLEN-1:0] expWord[$];
   int               pCount = 0;
   int               timeoutLimit = 0;
   int               cycleCount = 0;

   miniRvCore miniRvCore_i (
      .clk(clk), .rstn(rstn), .start(start), .rVld(rVld), .rData(rData),
      .rRdy(rRdy), .rAddr(rAddr), .rWEn(rWEn), .rWData(rWData),
      .rWStrobe(rWStrobe), .halt(halt)
   );

   always #2 clk = ~clk;

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic compare(input string name, input logic [`XLEN-1:0] expected,
                          input logic [`XLEN-1:0] actual);
      if (actual !== expected) begin
         abortRun($sformatf("Mismatch in %s: expected %h, actual %h",
                            name, expected, actual));
      end
   endtask

   // P lines preset memory, E lines hold the expected final words
   task automatic loadPatterns();
      int          fd;
      int          n;
      int          addr;
      logic [7:0]  tag;
      logic [`XLEN-1:0] word;
      string       line;
      for (int a = 0; a < memWords; a++) begin
         mem[a] = 32'hFACE0000 | a;
      end
      fd = $fopen("testbench/corePatterns.txt", "r");
      if (fd == 0) begin
         abortRun("cannot open testbench/corePatterns.txt");
      end
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, "%c %h %h", tag, addr, word);
         if (n == 3 && (tag == "P" || tag == "E")) begin
            if (addr < 0 || addr >= memWords) begin
               abortRun($sformatf("pattern address %0d is outside the memory", addr));
            end
            if (tag == "P") begin
               mem[addr] = word;
               pCount++;
            end else begin
               expAddr.push_back(addr);
               expWord.push_back(word);
            end
         end
      end
      $fclose(fd);
      if (pCount == 0 || expAddr.size() == 0) begin
         abortRun("pattern file has no program words or no expected words");
      end
      initMem = mem;
      timeoutLimit = pCount * 12 + 200;
   endtask

   // memory model, answers each request after 1 to 3 cycles
   initial begin
      int waitLeft;
      int a;
      rVld     = 1'b0;
      rData    = '0;
      waitLeft = 0;
      void'($urandom(32'h442763c0));
      loadPatterns();
      forever begin
         @(posedge clk);
         #0.5;
         if (rVld) begin
            rVld  = 1'b0;
            rData = '0;
         end else if (rstn && rRdy) begin
            if (waitLeft == 0) begin
               waitLeft = $urandom_range(3, 1);
            end
            waitLeft--;
            if (waitLeft == 0) begin
               if (rAddr >= memWords) begin
                  abortRun($sformatf("access to address %h outside the memory", rAddr));
               end
               a = int'(rAddr);
               if (rWEn) begin
                  for (int l = 0; l < `STROBE_W; l++) begin
                     if (rWStrobe[l]) mem[a][8*l +: 8] = rWData[8*l +: 8];
                  end
               end else begin
                  rData = mem[a];
               end
               rVld = 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
         abortRun($sformatf("core did not halt in time (%0d cycles)", cycleCount));
      end
   end

   task automatic stepCycle();
      @(posedge clk);
      #0.5;
   endtask

   task automatic checkIdle(input int count, input string label);
      for (int n = 0; n < count; n++) begin
         stepCycle();
         compare({label, " halt"}, 32'd1, 32'(halt));
         compare({label, " rRdy"}, 32'd0, 32'(rRdy));
      end
   endtask

   task automatic pulseStart();
      start = 1'b1;
      stepCycle();
      start = 1'b0;
      compare("startClearsHalt", 32'd0, 32'(halt));
   endtask

   task automatic waitForHalt();
      while (halt !== 1'b1) begin
         stepCycle();
      end
   endtask

   initial begin
      rstn  = 1'b0;
      start = 1'b0;
      repeat (5) @(posedge clk);
      #0.5;
      rstn = 1'b1;
      checkIdle(4, "afterReset");

      pulseStart();
      waitForHalt(); // opcode 7F
      checkIdle(3, "afterHaltOpcode");
      compare("storeAfterHaltWaits", initMem[resumeAddr], mem[resumeAddr]);

      pulseStart();
      waitForHalt(); // invalid encoding
      checkIdle(3, "afterInvalidWord");
      compare("storeAfterInvalidWaits", initMem[skipAddr], mem[skipAddr]);

      // the held store now writes x5, which the invalid word must not have touched
      pulseStart();
      waitForHalt();
      foreach (expAddr[k]) begin
         compare($sformatf("finalMem[%0d]", expAddr[k]), expWord[k], mem[expAddr[k]]);
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* verilog/miniRvCore.sv */
`include "coreCfg.svh"

module miniRvCore (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 start,
   input  logic                 rVld,
   input  logic [`XLEN-1:0]     rData,
   output logic                 rRdy,
   output logic [`XLEN-1:0]     rAddr,
   output logic                 rWEn,
   output logic [`XLEN-1:0]     rWData,
   output logic [`STROBE_W-1:0] rWStrobe,
   output logic                 halt
);

   import rvIsaPkg::*;
   import coreCtrlPkg::*;

   instWord_t              inst;
   aluOp_t                 aluOp;
   memSize_t               memSize;
   logic [`REG_ADDR_W-1:0] rs1;
   logic [`REG_ADDR_W-1:0] rs2;
   logic [`REG_ADDR_W-1:0] rd;
   logic [`XLEN-1:0]       imm;
   logic                   useImm;
   logic                   isLui;
   logic                   isLoad;
   logic                   isStore;
   logic                   writesRd;
   logic                   stop;
   logic                   loadSigned;
   logic                   regWe;
   logic                   loadPhase;
   logic [`XLEN-1:0]       rData1;
   logic [`XLEN-1:0]       rData2;
   logic [`XLEN-1:0]       opB;
   logic [`XLEN-1:0]       aluResult;
   logic [`XLEN-1:0]       wData;
   logic [`XLEN-1:0]       storeData;
   logic [`STROBE_W-1:0]   storeStrobe;
   logic [`XLEN-1:0]       loadData;

   assign opB   = useImm ? imm : rData2;
   assign wData = loadPhase ? loadData : (isLui ? imm : aluResult);

   busSequencer busSequencer_i (
      .clk(clk), .rstn(rstn), .start(start), .rVld(rVld), .rData(rData),
      .isLoad(isLoad), .isStore(isStore), .writesRd(writesRd), .stop(stop),
      .memAddr(aluResult), .storeData(storeData), .storeStrobe(storeStrobe),
      .inst(inst), .regWe(regWe), .loadPhase(loadPhase),
      .rRdy(rRdy), .rAddr(rAddr), .rWEn(rWEn), .rWData(rWData),
      .rWStrobe(rWStrobe), .halt(halt)
   );

   instDecoder instDecoder_i (
      .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .useImm(useImm),
      .isLui(isLui), .isLoad(isLoad), .isStore(isStore), .writesRd(writesRd),
      .stop(stop), .aluOp(aluOp), .memSize(memSize), .loadSigned(loadSigned)
   );

   aluUnit aluUnit_i (.aluOp(aluOp), .opA(rData1), .opB(opB), .result(aluResult));

   regFile regFile_i (
      .clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .rd(rd), .we(regWe),
      .wData(wData), .rData1(rData1), .rData2(rData2)
   );

   // store source is always rs2
   loadStoreAlign loadStoreAlign_i (
      .memSize(memSize), .loadSigned(loadSigned), .storeSrc(rData2), .rData(rData),
      .storeData(storeData), .storeStrobe(storeStrobe), .loadData(loadData)
   );

endmodule

/* verilog/loadStoreAlign.sv */
`include "coreCfg.svh"

module loadStoreAlign (
   input  coreCtrlPkg::memSize_t memSize,
   input  logic                  loadSigned,
   input  logic [`XLEN-1:0]      storeSrc,
   input  logic [`XLEN-1:0]      rData,
   output logic [`XLEN-1:0]      storeData,
   output logic [`STROBE_W-1:0]  storeStrobe,
   output logic [`XLEN-1:0]      loadData
);

   import coreCtrlPkg::*;

   always_comb begin
      case (memSize)
         memByte: begin
            storeData   = {{(`XLEN-8){1'b0}}, storeSrc[7:0]};
            storeStrobe = `STROBE_W'b0001;
            loadData    = {{(`XLEN-8){loadSigned & rData[7]}}, rData[7:0]};
         end
         memHalf: begin
            storeData   = {{(`XLEN-16){1'b0}}, storeSrc[15:0]};
            storeStrobe = `STROBE_W'b0011;
            loadData    = {{(`XLEN-16){loadSigned & rData[15]}}, rData[15:0]};
         end
         default: begin // whole word
            storeData   = storeSrc;
            storeStrobe = '1;
            loadData    = rData;
         end
      endcase
   end

endmodule

/* verilog/regFile.sv */
`include "coreCfg.svh"

module regFile (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [`REG_ADDR_W-1:0] rs1,
   input  logic [`REG_ADDR_W-1:0] rs2,
   input  logic [`REG_ADDR_W-1:0] rd,
   input  logic                   we,
   input  logic [`XLEN-1:0]       wData,
   output logic [`XLEN-1:0]       rData1,
   output logic [`XLEN-1:0]       rData2
);

   logic [`XLEN-1:0] regs [`NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && rd != '0) begin // x0 stays zero
         regs[rd] <= wData;
      end
   end

   assign rData1 = regs[rs1];
   assign rData2 = regs[rs2];

   assert property (@(posedge clk) disable iff (!rstn) (rs1 == '0) |-> (rData1 == '0));

endmodule

/* verilog/aluUnit.sv */
`include "coreCfg.svh"

module aluUnit (
   input  coreCtrlPkg::aluOp_t aluOp,
   input  logic [`XLEN-1:0]    opA,
   input  logic [`XLEN-1:0]    opB,
   output logic [`XLEN-1:0]    result
);

   import coreCtrlPkg::*;

   logic [`SHAMT_W-1:0] shamt;

   assign shamt = opB[`SHAMT_W-1:0]; // upper bits ignored

   always_comb begin
      case (aluOp)
         aluSub:  result = opA - opB;
         aluXor:  result = opA ^ opB;
         aluOr:   result = opA | opB;
         aluAnd:  result = opA & opB;
         aluSlt:  result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
         aluSltu: result = {{(`XLEN-1){1'b0}}, opA < opB};
         aluSll:  result = opA << shamt;
         aluSrl:  result = opA >> shamt;
         aluSra:  result = $signed(opA) >>> shamt;
         default: result = opA + opB; // also load/store address
      endcase
   end

endmodule

/* verilog/instDecoder.sv */
`include "coreCfg.svh"

module instDecoder (
   input  rvIsaPkg::instWord_t       inst,
   output logic [`REG_ADDR_W-1:0]    rs1,
   output logic [`REG_ADDR_W-1:0]    rs2,
   output logic [`REG_ADDR_W-1:0]    rd,
   output logic [`XLEN-1:0]          imm,
   output logic                      useImm,
   output logic                      isLui,
   output logic                      isLoad,
   output logic                      isStore,
   output logic                      writesRd,
   output logic                      stop,
   output coreCtrlPkg::aluOp_t       aluOp,
   output coreCtrlPkg::memSize_t     memSize,
   output logic                      loadSigned
);

   import rvIsaPkg::*;
   import coreCtrlPkg::*;

   always_comb begin
      rs1        = '0;
      rs2        = '0;
      rd         = '0;
      imm        = '0;
      useImm     = 1'b0;
      isLui      = 1'b0;
      isLoad     = 1'b0;
      isStore    = 1'b0;
      writesRd   = 1'b0;
      stop       = 1'b0;
      aluOp      = aluAdd;
      memSize    = memWord;
      loadSigned = 1'b0;

      case (inst.r.opcode)
         opReg: begin
            rs1      = inst.r.rs1;
            rs2      = inst.r.rs2;
            rd       = inst.r.rd;
            writesRd = 1'b1;
            if (inst.r.funct7 == 7'h00) begin
               case (inst.r.funct3)
                  3'b000: aluOp = aluAdd;
                  3'b001: aluOp = aluSll;
                  3'b010: aluOp = aluSlt;
                  3'b011: aluOp = aluSltu;
                  3'b100: aluOp = aluXor;
                  3'b101: aluOp = aluSrl;
                  3'b110: aluOp = aluOr;
                  default: aluOp = aluAnd;
               endcase
            end else if (inst.r.funct7 == 7'h20 && inst.r.funct3 == 3'b000) begin
               aluOp = aluSub;
            end else begin
               stop = 1'b1;
            end
         end
         opImm: begin
            rs1      = inst.i.rs1;
            rd       = inst.i.rd;
            imm      = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            useImm   = 1'b1;
            writesRd = 1'b1;
            case (inst.i.funct3)
               3'b000: aluOp = aluAdd;
               3'b010: aluOp = aluSlt;
               3'b011: aluOp = aluSltu;
               3'b100: aluOp = aluXor;
               3'b110: aluOp = aluOr;
               3'b111: aluOp = aluAnd;
               3'b001: begin
                  aluOp = aluSll;
                  stop  = (inst.r.funct7 != 7'h00); // shifts carry funct7 in the imm
               end
               default: begin // 101
                  if (inst.r.funct7 == 7'h00) aluOp = aluSrl;
                  else if (inst.r.funct7 == 7'h20) aluOp = aluSra;
                  else stop = 1'b1;
               end
            endcase
         end
         opLui: begin
            rd       = inst.u.rd;
            imm      = {inst.u.imm, 12'h000};
            isLui    = 1'b1;
            writesRd = 1'b1;
         end
         opLoad: begin
            rs1    = inst.i.rs1;
            rd     = inst.i.rd;
            imm    = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            useImm = 1'b1;
            isLoad = 1'b1;
            case (inst.i.funct3)
               3'b000: begin
                  memSize    = memByte;
                  loadSigned = 1'b1;
               end
               3'b001: begin
                  memSize    = memHalf;
                  loadSigned = 1'b1;
               end
               3'b010: memSize = memWord;
               3'b100: memSize = memByte;
               3'b101: memSize = memHalf;
               default: stop = 1'b1;
            endcase
         end
         opStore: begin
            rs1     = inst.s.rs1;
            rs2     = inst.s.rs2;
            imm     = {{(`XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            useImm  = 1'b1;
            isStore = 1'b1;
            case (inst.s.funct3)
               3'b000: memSize = memByte;
               3'b001: memSize = memHalf;
               3'b010: memSize = memWord;
               default: stop = 1'b1;
            endcase
         end
         default: stop = 1'b1; // opHalt and anything unknown
      endcase

      // a stopping word has no side effects
      if (stop) begin
         writesRd = 1'b0;
         isLoad   = 1'b0;
         isStore  = 1'b0;
      end
   end

endmodule

/* verilog/busSequencer.sv */
`include "coreCfg.svh"

module busSequencer (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   start,
   input  logic                   rVld,
   input  logic [`XLEN-1:0]       rData,
   input  logic                   isLoad,
   input  logic                   isStore,
   input  logic                   writesRd,
   input  logic                   stop,
   input  logic [`XLEN-1:0]       memAddr,
   input  logic [`XLEN-1:0]       storeData,
   input  logic [`STROBE_W-1:0]   storeStrobe,
   output rvIsaPkg::instWord_t    inst,
   output logic                   regWe,
   output logic                   loadPhase,
   output logic                   rRdy,
   output logic [`XLEN-1:0]       rAddr,
   output logic                   rWEn,
   output logic [`XLEN-1:0]       rWData,
   output logic [`STROBE_W-1:0]   rWStrobe,
   output logic                   halt
);

   localparam logic [1:0] stIdle  = 2'd0;
   localparam logic [1:0] stFetch = 2'd1;
   localparam logic [1:0] stExec  = 2'd2;
   localparam logic [1:0] stMem   = 2'd3;

   logic [1:0]       state;
   logic [`XLEN-1:0] pc;
   logic             loadPending;
   logic             fetchDone;
   logic             memIssue;

   assign fetchDone = (state == stFetch) && rRdy && rVld;
   assign memIssue  = (state == stExec) && !stop && (isLoad || isStore);

   // ALU/LUI write in execute, loads on the data beat
   assign regWe     = ((state == stExec) && writesRd && !stop) || (loadPending && rVld);
   assign loadPhase = loadPending;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state       <= stIdle;
         pc          <= '0;
         halt        <= 1'b1;
         rRdy        <= 1'b0;
         rWEn        <= 1'b0;
         loadPending <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               if (start) begin
                  halt  <= 1'b0;
                  rRdy  <= 1'b1;
                  state <= stFetch;
               end
            end
            stFetch: begin
               if (!rRdy) begin
                  rRdy <= 1'b1; // re-arm after a memory access
               end else if (rVld) begin
                  rRdy  <= 1'b0;
                  pc    <= pc + 1'b1; // word addressing
                  state <= stExec;
               end
            end
            stExec: begin
               if (stop) begin
                  halt  <= 1'b1;
                  state <= stIdle;
               end else if (isLoad || isStore) begin
                  rRdy        <= 1'b1;
                  rWEn        <= isStore;
                  loadPending <= isLoad;
                  state       <= stMem;
               end else begin
                  rRdy  <= 1'b1;
                  state <= stFetch;
               end
            end
            default: begin // stMem
               if (rVld) begin
                  rRdy        <= 1'b0;
                  rWEn        <= 1'b0;
                  loadPending <= 1'b0;
                  state       <= stFetch;
               end
            end
         endcase
      end
   end

   // request payload, only meaningful while rRdy
   always_ff @(posedge clk) begin
      if (fetchDone) begin
         inst <= rData;
      end
      if (memIssue) begin
         rAddr    <= memAddr;
         rWData   <= storeData;
         rWStrobe <= storeStrobe;
      end else if (!rRdy) begin
         rAddr <= pc;
      end
   end

   assert property (@(posedge clk) disable iff (!rstn) rWEn |-> rRdy);
   assert property (@(posedge clk) disable iff (!rstn) halt |-> !rRdy);

   // request held until the memory answers
   assert property (@(posedge clk) disable iff (!rstn)
      rRdy && !rVld |=> rRdy && $stable(rAddr));

endmodule

/* verilog/coreCtrlPkg.sv */
package coreCtrlPkg;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluOr,
      aluAnd,
      aluSlt,
      aluSltu,
      aluSll,
      aluSrl,
      aluSra
   } aluOp_t;

   // access width, always in the low lanes
   typedef enum logic [1:0] {
      memByte,
      memHalf,
      memWord
   } memSize_t;

endpackage

/* verilog/rvIsaPkg.sv */
`include "coreCfg.svh"

package rvIsaPkg;

   typedef enum logic [6:0] {
      opLoad  = 7'h03,
      opImm   = 7'h13,
      opStore = 7'h23,
      opReg   = 7'h33,
      opLui   = 7'h37,
      opHalt  = 7'h7F
   } opcode_t;

   typedef struct packed {
      logic [6:0]             funct7;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
   } rType_t;

   typedef struct packed {
      logic [11:0]            imm;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
   } iType_t;

   typedef struct packed {
      logic [6:0]             immHi;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [4:0]             immLo;
      logic [6:0]             opcode;
   } sType_t;

   typedef struct packed {
      logic [19:0]            imm;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
   } uType_t;

   // one fetched word, four views
   typedef union packed {
      rType_t r;
      iType_t i;
      sType_t s;
      uType_t u;
   } instWord_t;

endpackage

/* verilog/coreCfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define XLEN 32

// register file
`define REG_ADDR_W 5
`define NUM_REGS 32

// byte lanes per word
`define STROBE_W 4

// shift amount, low bits of the operand
`define SHAMT_W 5

`endif
